// File: rom_load_pkg.sv
/*
 * Shared definitions for the ROM download path
 *  - Widths of bytes, host addresses, file indices and memory words
 *  - Memory region enum
 *  - Host file indices for ROM image, protection type and DIP bank
 *  - Byte address limits of each region in the ROM image
 */

package rom_load_pkg;

	// ####################
	// Widths
	// ####################

	typedef logic [7:0]  byte_t;       // One download byte
	typedef logic [24:0] load_addr_t;  // Host byte address
	typedef logic [7:0]  file_index_t; // Host file index
	typedef logic [17:0] mem_addr_t;   // Word address inside a region, sized for GFX
	typedef logic [31:0] mem_data_t;   // Narrow words sit in the low bits

	// Target memory of a packed write
	typedef enum logic [1:0] {
		REGION_GFX,   // 32-bit graphics words
		REGION_MAIN,  // 16-bit CPU program words
		REGION_AUDIO, // Audio CPU bytes
		REGION_CHAR   // Character ROM bytes
	} rom_region_t;

	// ####################
	// File indices
	// ####################

	localparam file_index_t FILE_ROM  = 8'd0;   // ROM image
	localparam file_index_t FILE_SLAP = 8'd1;   // Protection chip type
	localparam file_index_t FILE_DIP  = 8'd254; // DIP switch bytes

	// ####################
	// ROM image map
	// ####################

	// Graphics, six banks of four interleaved chips
	localparam load_addr_t GFX_END      = 25'h0C0000;

	// CPU program, 9A/9B then filler, 10A/10B, then 7A..3B pairs
	localparam load_addr_t MAIN_BASE    = 25'h0C0000;
	localparam load_addr_t MAIN_GAP_LO  = 25'h0D0000; // Filler starts
	localparam load_addr_t MAIN_GAP_MID = 25'h0F0000; // 10A/10B inside the gap
	localparam load_addr_t MAIN_GAP_HI  = 25'h0F8000; // End of 10A/10B
	localparam load_addr_t MAIN_END     = 25'h140000;

	// Audio 16S and 16R back to back, then character ROM 6P
	localparam load_addr_t AUDIO_BASE   = 25'h140000;
	localparam load_addr_t CHAR_BASE    = 25'h14C000;
	localparam load_addr_t CHAR_END     = 25'h150000; // Anything above is dropped

endpackage

// File: download_rx.sv
/*
 * Host byte receiver
 *  - One-entry registered buffer between host loader and packer
 *  - Takes a new byte in the same cycle the held one leaves
 */

`timescale 1ns/1ps

module download_rx (
	input  logic                      clk_sys,
	input  logic                      arst_n,
	// Host side
	input  logic                      dl_valid,
	output logic                      dl_ready,
	input  rom_load_pkg::file_index_t dl_index,
	input  rom_load_pkg::load_addr_t  dl_addr,
	input  rom_load_pkg::byte_t       dl_data,
	// Packer side
	output logic                      byte_valid,
	input  logic                      byte_ready,
	output rom_load_pkg::file_index_t byte_index,
	output rom_load_pkg::load_addr_t  byte_addr,
	output rom_load_pkg::byte_t       byte_data
);

	logic full; // Buffer holds a byte

	// Open when empty or draining this cycle
	assign dl_ready   = !full || byte_ready;
	assign byte_valid = full;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			full <= 1'b0;
		end else if (dl_valid && dl_ready) begin
			full <= 1'b1; // Refill, possibly while emptying
		end else if (byte_ready) begin
			full <= 1'b0;
		end
	end

	// Payload capture on acceptance
	always_ff @(posedge clk_sys) begin
		if (dl_valid && dl_ready) begin
			byte_index <= dl_index;
			byte_addr  <= dl_addr;
			byte_data  <= dl_data;
		end
	end

endmodule

// File: rom_packer.sv
/*
 * ROM byte packer
 *  - 24-bit accumulator of index-0 bytes
 *  - Region decode and word address from the byte address
 *  - Word completion and hand-off on the pk port
 *  - Protection type and DIP byte routing as one-cycle strobes
 */

`timescale 1ns/1ps

module rom_packer (
	input  logic                      clk_sys,
	input  logic                      arst_n,
	// From receiver
	input  logic                      byte_valid,
	output logic                      byte_ready,
	input  rom_load_pkg::file_index_t byte_index,
	input  rom_load_pkg::load_addr_t  byte_addr,
	input  rom_load_pkg::byte_t       byte_data,
	// To write port
	output logic                      pk_valid,
	input  logic                      pk_ready,
	output rom_load_pkg::rom_region_t pk_region,
	output rom_load_pkg::mem_addr_t   pk_addr,
	output rom_load_pkg::mem_data_t   pk_data,
	// To config registers
	output logic                      slap_we,
	output logic                      dip_we,
	output rom_load_pkg::byte_t       cfg_offset,
	output rom_load_pkg::byte_t       cfg_data
);

	logic [23:0]              acc;      // Previous three ROM bytes
	logic                     is_rom;
	logic                     in_gfx;
	logic                     in_main;
	logic                     in_audio;
	logic                     in_char;
	logic                     complete; // Byte closes a word in its region
	logic                     word_done;
	rom_load_pkg::load_addr_t main_off;
	rom_load_pkg::load_addr_t audio_off;
	rom_load_pkg::load_addr_t char_off;

	// ####################
	// Region decode
	// ####################

	assign is_rom   = byte_index == rom_load_pkg::FILE_ROM;
	assign in_gfx   = byte_addr < rom_load_pkg::GFX_END;
	assign in_main  = (byte_addr >= rom_load_pkg::MAIN_BASE && byte_addr < rom_load_pkg::MAIN_GAP_LO)
		|| (byte_addr >= rom_load_pkg::MAIN_GAP_MID && byte_addr < rom_load_pkg::MAIN_GAP_HI)
		|| (byte_addr >= rom_load_pkg::MAIN_GAP_HI && byte_addr < rom_load_pkg::MAIN_END);
	assign in_audio = byte_addr >= rom_load_pkg::AUDIO_BASE && byte_addr < rom_load_pkg::CHAR_BASE;
	assign in_char  = byte_addr >= rom_load_pkg::CHAR_BASE && byte_addr < rom_load_pkg::CHAR_END;

	// Offsets from each region base
	assign main_off  = byte_addr - rom_load_pkg::MAIN_BASE;
	assign audio_off = byte_addr - rom_load_pkg::AUDIO_BASE;
	assign char_off  = byte_addr - rom_load_pkg::CHAR_BASE;

	// ####################
	// Word assembly
	// ####################

	always_comb begin
		complete  = 1'b0; // Gap and above CHAR_END never complete
		pk_region = rom_load_pkg::REGION_GFX;
		pk_addr   = byte_addr[19:2];       // Dword index
		pk_data   = {acc, byte_data};      // Oldest byte on top
		if (in_gfx) begin
			complete = byte_addr[1:0] == 2'b11; // Fourth byte of the dword
		end else if (in_main) begin
			complete  = byte_addr[0];          // Odd byte closes a word
			pk_region = rom_load_pkg::REGION_MAIN;
			pk_addr   = main_off[18:1];
			pk_data   = {16'h0000, acc[7:0], byte_data};
		end else if (in_audio) begin
			complete  = 1'b1;
			pk_region = rom_load_pkg::REGION_AUDIO;
			pk_addr   = audio_off[17:0];
			pk_data   = {24'h000000, byte_data};
		end else if (in_char) begin
			complete  = 1'b1;
			pk_region = rom_load_pkg::REGION_CHAR;
			pk_addr   = char_off[17:0];
			pk_data   = {24'h000000, byte_data};
		end
	end

	assign word_done = is_rom && complete;
	assign pk_valid  = byte_valid && word_done;
	assign byte_ready = word_done ? pk_ready : 1'b1; // Stall only on a full word

	// Every accepted ROM byte shifts in, gap bytes too
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			acc <= '0;
		end else if (byte_valid && byte_ready && is_rom) begin
			acc <= {acc[15:0], byte_data};
		end
	end

	// ####################
	// Config routing
	// ####################

	assign slap_we    = byte_valid && byte_index == rom_load_pkg::FILE_SLAP;
	assign dip_we     = byte_valid && byte_index == rom_load_pkg::FILE_DIP
		&& byte_addr[24:8] == '0;                 // First 256 bytes only
	assign cfg_offset = byte_addr[7:0];
	assign cfg_data   = byte_data;

endmodule

// File: config_regs.sv
/*
 * Game configuration registers
 *  - Protection chip type, 104 out of reset
 *  - Bank of DIP switch bytes written by offset
 */

`timescale 1ns/1ps

module config_regs #(
	parameter int DIP_BYTES = 8 // 1 to 256
) (
	input  logic                     clk_sys,
	input  logic                     arst_n,
	input  logic                     slap_we,
	input  logic                     dip_we,
	input  rom_load_pkg::byte_t      cfg_offset,
	input  rom_load_pkg::byte_t      cfg_data,
	output rom_load_pkg::byte_t      slap_type,
	output logic [DIP_BYTES*8-1:0]   dip_switches
);

	// Protection type, 104 is the first game
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			slap_type <= 8'd104;
		end else if (slap_we) begin
			slap_type <= cfg_data;
		end
	end

	// One register per switch byte
	// Offsets past the bank match no byte and are dropped
	for (genvar i = 0; i < DIP_BYTES; i++) begin : g_dip
		always_ff @(posedge clk_sys or negedge arst_n) begin
			if (!arst_n) begin
				dip_switches[i*8 +: 8] <= 8'h00;
			end else if (dip_we && cfg_offset == 8'(i)) begin
				dip_switches[i*8 +: 8] <= cfg_data;
			end
		end
	end

endmodule

// File: write_port.sv
/*
 * Memory write port
 *  - One-entry output register, held stable under back-pressure
 *  - Reloads in the same cycle the held write leaves
 */

`timescale 1ns/1ps

module write_port (
	input  logic                      clk_sys,
	input  logic                      arst_n,
	// From packer
	input  logic                      pk_valid,
	output logic                      pk_ready,
	input  rom_load_pkg::rom_region_t pk_region,
	input  rom_load_pkg::mem_addr_t   pk_addr,
	input  rom_load_pkg::mem_data_t   pk_data,
	// To memory
	output logic                      wr_valid,
	input  logic                      wr_ready,
	output rom_load_pkg::rom_region_t wr_region,
	output rom_load_pkg::mem_addr_t   wr_addr,
	output rom_load_pkg::mem_data_t   wr_data
);

	assign pk_ready = !wr_valid || wr_ready; // Empty or leaving now

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			wr_valid <= 1'b0;
		end else if (pk_valid && pk_ready) begin
			wr_valid <= 1'b1;
		end else if (wr_ready) begin
			wr_valid <= 1'b0; // Taken, nothing behind it
		end
	end

	always_ff @(posedge clk_sys) begin
		if (pk_valid && pk_ready) begin
			wr_region <= pk_region;
			wr_addr   <= pk_addr;
			wr_data   <= pk_data;
		end
	end

endmodule

// File: rom_load_top.sv
/*
 * ROM download path top level
 *  - Receiver, packer, config registers and write port
 */

`timescale 1ns/1ps

module rom_load_top #(
	parameter int DIP_BYTES = 8
) (
	input  logic                      clk_sys,
	input  logic                      arst_n,
	// Host loader
	input  logic                      dl_valid,
	output logic                      dl_ready,
	input  rom_load_pkg::file_index_t dl_index,
	input  rom_load_pkg::load_addr_t  dl_addr,
	input  rom_load_pkg::byte_t       dl_data,
	// Memory write
	output logic                      wr_valid,
	input  logic                      wr_ready,
	output rom_load_pkg::rom_region_t wr_region,
	output rom_load_pkg::mem_addr_t   wr_addr,
	output rom_load_pkg::mem_data_t   wr_data,
	// Game config
	output rom_load_pkg::byte_t       slap_type,
	output logic [DIP_BYTES*8-1:0]    dip_switches
);

	// Receiver to packer
	logic                      byte_valid;
	logic                      byte_ready;
	rom_load_pkg::file_index_t byte_index;
	rom_load_pkg::load_addr_t  byte_addr;
	rom_load_pkg::byte_t       byte_data;

	// Packer to write port
	logic                      pk_valid;
	logic                      pk_ready;
	rom_load_pkg::rom_region_t pk_region;
	rom_load_pkg::mem_addr_t   pk_addr;
	rom_load_pkg::mem_data_t   pk_data;

	// Config strobes
	logic                      slap_we;
	logic                      dip_we;
	rom_load_pkg::byte_t       cfg_offset;
	rom_load_pkg::byte_t       cfg_data;

	download_rx download_rx_i (.*);

	rom_packer rom_packer_i (.*);

	config_regs #(
		.DIP_BYTES(DIP_BYTES)
	) config_regs_i (.*);

	write_port write_port_i (.*);

endmodule

// File: tb_rom_load_assert.sv
/*
 * Protocol checks bound into the ROM download top level
 *  - Reset values of wr_valid and dl_ready
 *  - Write payload held under back-pressure
 *  - No unknown payload bits on a valid write
 */

`timescale 1ns/1ps

module rom_load_assert (
	input logic                      clk_sys,
	input logic                      arst_n,
	input logic                      dl_ready,
	input logic                      wr_valid,
	input logic                      wr_ready,
	input rom_load_pkg::rom_region_t wr_region,
	input rom_load_pkg::mem_addr_t   wr_addr,
	input rom_load_pkg::mem_data_t   wr_data
);

	// Empty buffers in reset
	a_reset_values: assert property (@(posedge clk_sys) !arst_n |-> !wr_valid && dl_ready)
		else $error("wr_valid or dl_ready not at its reset value");

	a_hold_stable: assert property (@(posedge clk_sys) disable iff (!arst_n)
		wr_valid && !wr_ready |=> wr_valid && $stable(wr_region) && $stable(wr_addr)
			&& $stable(wr_data))
		else $error("Write changed while the memory stalled");

	a_known_payload: assert property (@(posedge clk_sys) disable iff (!arst_n)
		wr_valid |-> !$isunknown({wr_region, wr_addr, wr_data}))
		else $error("Unknown bits on a valid write");

endmodule

bind rom_load_top rom_load_assert rom_load_assert_i (
	.clk_sys  (clk_sys),
	.arst_n   (arst_n),
	.dl_ready (dl_ready),
	.wr_valid (wr_valid),
	.wr_ready (wr_ready),
	.wr_region(wr_region),
	.wr_addr  (wr_addr),
	.wr_data  (wr_data)
);

// File: tb_rom_load.sv
/*
 * Testbench for the ROM download path
 *  - Clock, reset and LFSR paced host byte stream
 *  - Reference packer model with an ordered queue of expected writes
 *  - Memory side with random and long back-pressure
 *  - Config register checks and cycle limit
 */

`timescale 1ns/1ps

module tb_rom_load;

	logic                      clk_sys;
	logic                      arst_n;
	logic                      dl_valid;
	logic                      dl_ready;
	rom_load_pkg::file_index_t dl_index;
	rom_load_pkg::load_addr_t  dl_addr;
	rom_load_pkg::byte_t       dl_data;
	logic                      wr_valid;
	logic                      wr_ready;
	rom_load_pkg::rom_region_t wr_region;
	rom_load_pkg::mem_addr_t   wr_addr;
	rom_load_pkg::mem_data_t   wr_data;
	rom_load_pkg::byte_t       slap_type;
	logic [63:0]               dip_switches;

	// Host stream, one entry per byte
	rom_load_pkg::file_index_t q_index[$];
	rom_load_pkg::load_addr_t  q_addr[$];
	rom_load_pkg::byte_t       q_data[$];
	// Expected memory writes in order
	rom_load_pkg::rom_region_t exp_region[$];
	rom_load_pkg::mem_addr_t   exp_addr[$];
	rom_load_pkg::mem_data_t   exp_data[$];

	logic [31:0]         lfsr;
	logic [23:0]         model_acc = '0;      // Last three ROM bytes
	rom_load_pkg::byte_t slap_exp  = 8'd104;
	logic [63:0]         dip_exp   = '0;
	int                  next_idx  = 0;       // Next stream byte to offer
	int                  taken     = 0;       // Bytes accepted by the DUT
	int                  bp_start;            // First byte of the stall phase
	int                  cycles    = 0;
	int                  limit;
	int                  n_writes  = 0;

	rom_load_top #(
		.DIP_BYTES(8)
	) rom_load_top_i (.*);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// ####################
	// Helpers
	// ####################

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [7:0] rand_bits(input int n);
		logic [7:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr); // One step per bit
			r    = {r[6:0], lfsr[0]};
		end
		return r;
	endfunction

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Result: FAILED");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
		assert (got === exp)
		else report_failure($sformatf("Mismatch at %0t ns: %s got %h expected %h",
			$time, name, got, exp));
	endtask

	task automatic add_byte(input rom_load_pkg::file_index_t idx,
		input rom_load_pkg::load_addr_t a, input rom_load_pkg::byte_t d);
		q_index.push_back(idx);
		q_addr.push_back(a);
		q_data.push_back(d);
	endtask

	task automatic push_write(input rom_load_pkg::rom_region_t r,
		input rom_load_pkg::mem_addr_t a, input rom_load_pkg::mem_data_t d);
		exp_region.push_back(r);
		exp_addr.push_back(a);
		exp_data.push_back(d);
	endtask

	// Packing rules applied to each accepted byte
	task automatic model_byte(input rom_load_pkg::file_index_t idx,
		input rom_load_pkg::load_addr_t a, input rom_load_pkg::byte_t d);
		if (idx == rom_load_pkg::FILE_SLAP) slap_exp = d;
		if (idx == rom_load_pkg::FILE_DIP && a < 25'd8) dip_exp[{a[2:0], 3'b000} +: 8] = d;
		if (idx == rom_load_pkg::FILE_ROM) begin
			if (a < rom_load_pkg::GFX_END) begin
				if (a[1:0] == 2'b11) push_write(rom_load_pkg::REGION_GFX, 18'(a >> 2), {model_acc, d});
			end else if (a < rom_load_pkg::MAIN_END) begin
				// Filler gap stores nothing
				if (a[0] && (a < rom_load_pkg::MAIN_GAP_LO || a >= rom_load_pkg::MAIN_GAP_MID))
					push_write(rom_load_pkg::REGION_MAIN, 18'((a - rom_load_pkg::MAIN_BASE) >> 1),
						{16'h0000, model_acc[7:0], d});
			end else if (a < rom_load_pkg::CHAR_BASE) begin
				push_write(rom_load_pkg::REGION_AUDIO, 18'(a - rom_load_pkg::AUDIO_BASE), {24'h0, d});
			end else if (a < rom_load_pkg::CHAR_END) begin
				push_write(rom_load_pkg::REGION_CHAR, 18'(a - rom_load_pkg::CHAR_BASE), {24'h0, d});
			end
			model_acc = {model_acc[15:0], d}; // Gap and dropped bytes shift too
		end
	endtask

	// One falling edge of host and memory stimulus
	task automatic drive_cycle();
		@(negedge clk_sys);
		if (next_idx >= bp_start) wr_ready = rand_bits(4) == 8'd0; // Long stalls
		else wr_ready = rand_bits(1) == 8'd1;
		if (taken == next_idx) begin                                // Held byte gone
			if (next_idx < q_index.size() && rand_bits(2) != 8'd0) begin
				dl_index = q_index[next_idx];
				dl_addr  = q_addr[next_idx];
				dl_data  = q_data[next_idx];
				dl_valid = 1'b1;
				next_idx++;
			end else begin
				dl_valid = 1'b0;
			end
		end
	endtask

	// ####################
	// Monitor
	// ####################

	always @(posedge clk_sys) begin
		cycles++;
		if (cycles > limit) report_failure("Timeout, the download did not finish in time");
		if (dl_valid && dl_ready) begin
			model_byte(dl_index, dl_addr, dl_data);
			taken++;
		end
		if (wr_valid && wr_ready) begin
			if (exp_region.size() == 0) report_failure("Memory write that the model did not expect");
			check_value("wr_region", 64'(wr_region), 64'(exp_region.pop_front()));
			check_value("wr_addr", 64'(wr_addr), 64'(exp_addr.pop_front()));
			check_value("wr_data", 64'(wr_data), 64'(exp_data.pop_front()));
			n_writes++;
		end
	end

	// ####################
	// Sequence
	// ####################

	initial begin
		rom_load_pkg::load_addr_t bases[7];
		lfsr     = 32'h828cb51e;
		arst_n   = 1'b0;
		dl_valid = 1'b0;
		dl_index = '0;
		dl_addr  = '0;
		dl_data  = '0;
		wr_ready = 1'b0;
		bases    = '{rom_load_pkg::MAIN_BASE, rom_load_pkg::MAIN_GAP_LO,
			rom_load_pkg::MAIN_GAP_MID, rom_load_pkg::MAIN_GAP_HI, rom_load_pkg::AUDIO_BASE,
			rom_load_pkg::CHAR_BASE, rom_load_pkg::CHAR_END};
		for (int i = 0; i < 64; i++) add_byte(rom_load_pkg::FILE_ROM, 25'(i), rand_bits(8));
		for (int b = 0; b < 7; b++)
			for (int i = 0; i < 6; i++) add_byte(rom_load_pkg::FILE_ROM, bases[b] + 25'(i), rand_bits(8));
		for (int i = 0; i < 4; i++) add_byte(8'd7, 25'(i), rand_bits(8)); // Unknown index
		add_byte(rom_load_pkg::FILE_SLAP, '0, rand_bits(8) | 8'h01); // Odd, never 104
		for (int i = 0; i < 8; i++) begin
			add_byte(rom_load_pkg::FILE_DIP, 25'(i), rand_bits(8) | 8'h01); // Never the reset 0
		end
		add_byte(rom_load_pkg::FILE_DIP, 25'd9, rand_bits(8) & 8'hFE); // Past the bank, even
		bp_start = q_index.size();
		for (int i = 64; i < 192; i++) add_byte(rom_load_pkg::FILE_ROM, 25'(i), rand_bits(8));
		for (int i = 16; i < 48; i++)
			add_byte(rom_load_pkg::FILE_ROM, rom_load_pkg::MAIN_BASE + 25'(i), rand_bits(8));
		limit = 4 * q_index.size() + 2000;

		repeat (16) @(posedge clk_sys);
		@(negedge clk_sys);
		arst_n = 1'b1;
		while (next_idx < q_index.size() || taken < next_idx) drive_cycle();
		while (exp_region.size() != 0 || wr_valid) drive_cycle(); // Drain the port
		@(negedge clk_sys);
		check_value("slap_type", 64'(slap_type), 64'(slap_exp));
		check_value("dip_switches", dip_switches, dip_exp);
		// 16 GFX, 9 MAIN, 6 AUDIO, 6 CHAR, then 32 GFX and 16 MAIN
		if (n_writes != 85) begin
			report_failure($sformatf("Wrong number of memory writes, %0d instead of 85", n_writes));
		end else begin
			$display("Result: PASSED");
			$finish;
		end
	end

endmodule

// File: tb.f
rom_load_pkg.sv
download_rx.sv
rom_packer.sv
config_regs.sv
write_port.sv
rom_load_top.sv
tb_rom_load_assert.sv
tb_rom_load.sv

// File: Makefile
LOG := sim.log

.PHONY: simulate clean

simulate:
	verilator --binary --timing --assert -f tb.f --top-module tb_rom_load -Mdir obj_dir
	./obj_dir/Vtb_rom_load > $(LOG) 2>&1 || echo "Result: FAILED" >> $(LOG)
	cat $(LOG)
	! grep -q "Result: FAILED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
